// ==== dv/cam_key_golden.txt ====
# C channel lower upper mode : new camera line with its key setup (hex)
# P high_byte low_byte expected_rgb expected_mask ; V : vsync, new frame
# frame 1: camera image, green and red channels, full last row
C 0 00 FF 0 P F8 00 F80000 1 P 07 E0 00FC00 1 P 00 1F 0000F8 1
  P FF FF F8FCF8 1 P 00 00 000000 1
C 0 00 FF 1 P F8 00 000000 1 P 07 E0 FCFCFC 1 P 00 1F 000000 1
C 1 00 FF 1 P F8 00 F8F8F8 1 P 07 E0 000000 1 P 00 1F 000000 1
C 0 00 FF 0 P F8 00 F80000 1 P 07 E0 00FC00 1 P 00 1F 0000F8 1
  P FF FF F8FCF8 1 P 00 00 000000 1 P F8 00 F80000 1
  P 07 E0 00FC00 1 P 00 1F 0000F8 1
V
# frame 2: blue, invalid code, Y and Cr
C 2 00 FF 1 P F8 00 000000 1 P 07 E0 000000 1 P 00 1F F8F8F8 1
C 3 00 FF 1 P F8 00 000000 1 P 07 E0 000000 1 P 00 1F 000000 1
C 4 00 FF 1 P F8 00 505050 1 P 07 E0 8F8F8F 1 P 00 1F 282828 1
C 5 00 FF 1 P F8 00 EDEDED 1 P 07 E0 232323 1 P 00 1F 6F6F6F 1
V
# frame 3: Cb, invalid code, mask on Y with bounds hit and just missed
C 6 00 FF 1 P F8 00 5B5B5B 1 P 07 E0 373737 1 P 00 1F EDEDED 1
C 7 00 FF 1 P F8 00 000000 1 P 07 E0 000000 1 P 00 1F 000000 1
C 4 28 8F 2 P F8 00 FFFFFF 1 P 07 E0 FFFFFF 1 P 00 1F FFFFFF 1
  P FF FF 000000 0 P 00 00 000000 0
C 4 29 8E 2 P F8 00 FFFFFF 1 P 07 E0 000000 0 P 00 1F 000000 0
V
# frame 4: overlay keyed on red
C 1 F0 FF 3 P F8 00 FF00FF 1 P 07 E0 8F8F8F 0 P FF FF FF00FF 1
  P 00 00 101010 0

// ==== filelist.f ====
+incdir+rtl
rtl/cam_pkg.sv
rtl/pixel_reconstruct.sv
rtl/rgb_align_pipe.sv
rtl/ycrcb_convert.sv
rtl/key_compositor.sv
rtl/cam_key_top.sv
dv/cam_key_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera key testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f filelist.f --top-module cam_key_tb \
  --Mdir obj_dir -o cam_key_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cam_key_sim > sim.log 2>&1
rc=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// ==== dv/cam_key_tb.sv ====
`include "cam_config.svh"

module cam_key_tb
  import cam_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TB_H_PIXELS = 8;
  localparam int TB_V_LINES  = 4;

  logic                     clk_camera = 1'b0;
  logic                     recent_reset;
  logic [7:0]               camera_d;
  logic                     cam_pclk;
  logic                     cam_hsync;
  logic                     cam_vsync;
  channel_e                 channel_sel;
  logic [7:0]               lower_thresh;
  logic [7:0]               upper_thresh;
  display_mode_e            display_mode;
  logic                     pixel_valid_o;
  logic [`CAM_HCOUNT_W-1:0] pixel_hcount_o;
  logic [`CAM_VCOUNT_W-1:0] pixel_vcount_o;
  logic [23:0]              pixel_rgb_o;
  logic                     pixel_mask_o;
  logic                     frame_end_o;

  // one entry per golden file record
  byte         op_kind[$];
  logic [31:0] op_a[$];
  logic [31:0] op_b[$];
  logic [31:0] op_c[$];
  logic [31:0] op_d[$];
  int          pixel_total;

  // expected pixels in output order
  logic [23:0] exp_rgb_q[$];
  bit          exp_mask_q[$];
  int          exp_h_q[$];
  int          exp_v_q[$];
  bit          exp_fe_q[$];
  int          exp_cycle_q[$];

  int cycle_cnt = 0;

  cam_key_top #(.H_PIXELS(TB_H_PIXELS), .V_LINES(TB_V_LINES)) dut (
    .clk_camera, .recent_reset,
    .camera_d_i(camera_d), .cam_pclk_i(cam_pclk),
    .cam_hsync_i(cam_hsync), .cam_vsync_i(cam_vsync),
    .channel_sel_i(channel_sel), .lower_thresh_i(lower_thresh),
    .upper_thresh_i(upper_thresh), .display_mode_i(display_mode),
    .pixel_valid_o, .pixel_hcount_o, .pixel_vcount_o,
    .pixel_rgb_o, .pixel_mask_o, .frame_end_o
  );

  // 4 ns camera clock
  always #2 clk_camera = ~clk_camera;

  // posedge counter sampled on falling edges
  always @(posedge clk_camera) cycle_cnt <= cycle_cnt + 1;

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_camera);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: time %0t %s expected %0h got %0h", $time, name, exp, got);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // ======================================================================
  // golden file
  // ======================================================================
  task automatic load_golden();
    int    fd;
    int    r;
    string tok;
    string rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("dv/cam_key_golden.txt", "r");
    assert (fd != 0) else begin
      $display("Error: the golden file dv/cam_key_golden.txt could not be opened");
      $display("Test failed");
      $fatal(1);
    end
    pixel_total = 0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        // comment runs to end of line
        r = $fgets(rest, fd);
      end else if (tok == "C" || tok == "P") begin
        r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        assert (r == 4) else begin
          $display("Error: a golden record is missing fields");
          $display("Test failed");
          $fatal(1);
        end
        op_kind.push_back(tok == "C" ? "C" : "P");
        op_a.push_back(a);
        op_b.push_back(b);
        op_c.push_back(c);
        op_d.push_back(d);
        if (tok == "P") pixel_total++;
      end else begin
        assert (tok == "V") else begin
          $display("Error: unknown record %s in the golden file", tok);
          $display("Test failed");
          $fatal(1);
        end
        op_kind.push_back("V");
        op_a.push_back(0);
        op_b.push_back(0);
        op_c.push_back(0);
        op_d.push_back(0);
      end
    end
    $fclose(fd);
  endtask

  // ======================================================================
  // camera bus driver
  // ======================================================================
  // pclk low two cycles then high two with data set while low
  task automatic send_byte(input logic [7:0] b, output int rise_cycle);
    @(negedge clk_camera);
    camera_d = b;
    cam_pclk = 1'b0;
    @(negedge clk_camera);
    @(negedge clk_camera);
    cam_pclk   = 1'b1;
    rise_cycle = cycle_cnt;
    @(negedge clk_camera);
  endtask

  task automatic end_line();
    wait_cycles(2);
    cam_pclk  = 1'b0;
    cam_hsync = 1'b0;
    // pipeline drains before the next setup change
    wait_cycles(12);
  endtask

  task automatic drive_all();
    bit open;
    int h;
    int v;
    int rise;
    open = 0;
    h = 0;
    v = 0;
    for (int i = 0; i < op_kind.size(); i++) begin
      if (op_kind[i] == "C") begin
        if (open) begin
          end_line();
          v++;
        end
        channel_sel  = channel_e'(op_a[i][2:0]);
        lower_thresh = op_b[i][7:0];
        upper_thresh = op_c[i][7:0];
        display_mode = display_mode_e'(op_d[i][1:0]);
        wait_cycles(2);
        cam_hsync = 1'b1;
        wait_cycles(2);
        open = 1;
        h = 0;
      end else if (op_kind[i] == "P") begin
        send_byte(op_a[i][7:0], rise);
        send_byte(op_b[i][7:0], rise);
        exp_rgb_q.push_back(op_c[i][23:0]);
        exp_mask_q.push_back(op_d[i][0]);
        exp_h_q.push_back(h);
        exp_v_q.push_back(v);
        // frame end belongs to the last column of the last row
        exp_fe_q.push_back(h == TB_H_PIXELS - 1 && v == TB_V_LINES - 1);
        // two synchronizer flops then five pipeline cycles
        exp_cycle_q.push_back(rise + 7);
        h++;
      end else begin
        if (open) begin
          end_line();
          open = 0;
        end
        cam_vsync = 1'b1;
        wait_cycles(4);
        cam_vsync = 1'b0;
        wait_cycles(4);
        v = 0;
      end
    end
    if (open) end_line();
    // last pixels leave the pipeline
    while (exp_rgb_q.size() != 0) begin
      @(negedge clk_camera);
    end
    wait_cycles(4);
  endtask

  // ======================================================================
  // output monitor
  // ======================================================================
  task automatic check_outputs();
    if (pixel_valid_o) begin
      assert (exp_rgb_q.size() != 0) else begin
        $display("Error: time %0t pixel_valid_o pulsed with no pixel left to expect", $time);
        $display("Test failed");
        $fatal(1);
      end
      compare_field("pixel_rgb_o", pixel_rgb_o, exp_rgb_q.pop_front());
      compare_field("pixel_mask_o", pixel_mask_o, exp_mask_q.pop_front());
      compare_field("pixel_hcount_o", pixel_hcount_o, exp_h_q.pop_front());
      compare_field("pixel_vcount_o", pixel_vcount_o, exp_v_q.pop_front());
      compare_field("frame_end_o", frame_end_o, exp_fe_q.pop_front());
      compare_field("pixel_valid_o cycle", cycle_cnt, exp_cycle_q.pop_front());
    end else begin
      // flags stay low between strobes
      compare_field("pixel_mask_o", pixel_mask_o, 0);
      compare_field("frame_end_o", frame_end_o, 0);
    end
  endtask

  initial begin
    int limit_cycles;
    recent_reset = 1'b1;
    camera_d     = 8'h00;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    channel_sel  = CH_GREEN;
    lower_thresh = 8'h00;
    upper_thresh = 8'hFF;
    display_mode = MODE_CAMERA;
    load_golden();
    limit_cycles = 2 * pixel_total * 16 + 200;
    wait_cycles(5);
    recent_reset = 1'b0;
    wait_cycles(3);
    // outputs idle after reset before any pclk edge
    compare_field("pixel_valid_o", pixel_valid_o, 0);
    compare_field("pixel_mask_o", pixel_mask_o, 0);
    compare_field("frame_end_o", frame_end_o, 0);
    compare_field("pixel_hcount_o", pixel_hcount_o, 0);
    compare_field("pixel_vcount_o", pixel_vcount_o, 0);
    fork
      drive_all();
      forever begin
        @(negedge clk_camera);
        check_outputs();
      end
      begin
        #(limit_cycles * 4);
        $display("Error: time %0t watchdog expired before all pixels came out", $time);
        $display("Test failed");
        $fatal(1);
      end
    join_any
    $display("Test passed");
    $finish;
  end

endmodule

// ==== rtl/cam_key_top.sv ====
`include "cam_config.svh"

module cam_key_top
  import cam_pkg::*;
#(
  parameter int H_PIXELS = `CAM_H_PIXELS,
  parameter int V_LINES  = `CAM_V_LINES
) (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  // camera bus
  input  logic [7:0]               camera_d_i,
  input  logic                     cam_pclk_i,
  input  logic                     cam_hsync_i,
  input  logic                     cam_vsync_i,
  // key configuration
  input  channel_e                 channel_sel_i,
  input  logic [7:0]               lower_thresh_i,
  input  logic [7:0]               upper_thresh_i,
  input  display_mode_e            display_mode_i,
  // composited pixel stream
  output logic                     pixel_valid_o,
  output logic [`CAM_HCOUNT_W-1:0] pixel_hcount_o,
  output logic [`CAM_VCOUNT_W-1:0] pixel_vcount_o,
  output logic [23:0]              pixel_rgb_o,
  output logic                     pixel_mask_o,
  output logic                     frame_end_o
);

  // rebuilt pixel, fans out to both branches
  logic                     px_valid;
  logic [`CAM_PIXEL_W-1:0]  px_data;
  logic [`CAM_HCOUNT_W-1:0] px_hcount;
  logic [`CAM_VCOUNT_W-1:0] px_vcount;
  logic                     px_frame_end;

  // rgb branch, delayed to match the converter
  logic                     al_valid;
  logic [`CAM_COLOR_W-1:0]  al_r;
  logic [`CAM_COLOR_W-1:0]  al_g;
  logic [`CAM_COLOR_W-1:0]  al_b;
  logic [`CAM_HCOUNT_W-1:0] al_hcount;
  logic [`CAM_VCOUNT_W-1:0] al_vcount;
  logic                     al_frame_end;

  // ycrcb branch
  logic [`CAM_COLOR_W-1:0]  yc_y;
  logic [`CAM_COLOR_W-1:0]  yc_cr;
  logic [`CAM_COLOR_W-1:0]  yc_cb;

  pixel_reconstruct #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) u_reconstruct (
    .clk_camera, .recent_reset,
    .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
    .px_valid_o(px_valid), .px_data_o(px_data),
    .px_hcount_o(px_hcount), .px_vcount_o(px_vcount),
    .frame_end_o(px_frame_end)
  );

  rgb_align_pipe u_align (
    .clk_camera, .recent_reset,
    .px_valid_i(px_valid), .px_data_i(px_data),
    .px_hcount_i(px_hcount), .px_vcount_i(px_vcount), .frame_end_i(px_frame_end),
    .al_valid_o(al_valid), .al_r_o(al_r), .al_g_o(al_g), .al_b_o(al_b),
    .al_hcount_o(al_hcount), .al_vcount_o(al_vcount), .al_frame_end_o(al_frame_end)
  );

  // strobe matches al_valid, the compositor keys off the rgb branch
  ycrcb_convert u_convert (
    .clk_camera, .recent_reset,
    .px_valid_i(px_valid), .px_data_i(px_data),
    .yc_valid_o(), .yc_y_o(yc_y), .yc_cr_o(yc_cr), .yc_cb_o(yc_cb)
  );

  key_compositor u_compositor (
    .clk_camera, .recent_reset,
    .al_valid_i(al_valid), .al_r_i(al_r), .al_g_i(al_g), .al_b_i(al_b),
    .al_hcount_i(al_hcount), .al_vcount_i(al_vcount), .al_frame_end_i(al_frame_end),
    .yc_y_i(yc_y), .yc_cr_i(yc_cr), .yc_cb_i(yc_cb),
    .channel_sel_i, .lower_thresh_i, .upper_thresh_i, .display_mode_i,
    .pixel_valid_o, .pixel_hcount_o, .pixel_vcount_o,
    .pixel_rgb_o, .pixel_mask_o, .frame_end_o
  );

endmodule

// ==== rtl/key_compositor.sv ====
`include "cam_config.svh"

module key_compositor
  import cam_pkg::*;
(
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     al_valid_i,
  input  logic [`CAM_COLOR_W-1:0]  al_r_i,
  input  logic [`CAM_COLOR_W-1:0]  al_g_i,
  input  logic [`CAM_COLOR_W-1:0]  al_b_i,
  input  logic [`CAM_HCOUNT_W-1:0] al_hcount_i,
  input  logic [`CAM_VCOUNT_W-1:0] al_vcount_i,
  input  logic                     al_frame_end_i,
  input  logic [`CAM_COLOR_W-1:0]  yc_y_i,
  input  logic [`CAM_COLOR_W-1:0]  yc_cr_i,
  input  logic [`CAM_COLOR_W-1:0]  yc_cb_i,
  input  channel_e                 channel_sel_i,
  input  logic [7:0]               lower_thresh_i,
  input  logic [7:0]               upper_thresh_i,
  input  display_mode_e            display_mode_i,
  output logic                     pixel_valid_o,
  output logic [`CAM_HCOUNT_W-1:0] pixel_hcount_o,
  output logic [`CAM_VCOUNT_W-1:0] pixel_vcount_o,
  output logic [23:0]              pixel_rgb_o,
  output logic                     pixel_mask_o,
  output logic                     frame_end_o
);

  logic [`CAM_COLOR_W-1:0] chan;
  logic                    mask_hit;
  logic [23:0]             rgb_next;

  // channel select, invalid codes give zero
  always_comb begin
    case (channel_sel_i)
      CH_GREEN: chan = al_g_i;
      CH_RED:   chan = al_r_i;
      CH_BLUE:  chan = al_b_i;
      CH_Y:     chan = yc_y_i;
      CH_CR:    chan = yc_cr_i;
      CH_CB:    chan = yc_cb_i;
      default:  chan = '0;
    endcase
  end

  // key test, both bounds inclusive
  assign mask_hit = (chan >= lower_thresh_i) && (chan <= upper_thresh_i);

  // ======================================================================
  // display mode mux
  // ======================================================================
  always_comb begin
    case (display_mode_i)
      MODE_CAMERA:  rgb_next = {al_r_i, al_g_i, al_b_i};
      MODE_CHANNEL: rgb_next = {chan, chan, chan};
      MODE_MASK:    rgb_next = {24{mask_hit}};
      MODE_OVERLAY: rgb_next = mask_hit ? `CAM_MASK_COLOR : {yc_y_i, yc_y_i, yc_y_i};
      default:      rgb_next = '0;
    endcase
  end

  // color output, only meaningful with the strobe
  always_ff @(posedge clk_camera) begin
    if (al_valid_i) begin
      pixel_rgb_o <= rgb_next;
    end
  end

  // flags are forced low outside the strobe cycle
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pixel_valid_o  <= 1'b0;
      pixel_mask_o   <= 1'b0;
      frame_end_o    <= 1'b0;
      pixel_hcount_o <= '0;
      pixel_vcount_o <= '0;
    end else begin
      pixel_valid_o <= al_valid_i;
      pixel_mask_o  <= al_valid_i & mask_hit;
      frame_end_o   <= al_valid_i & al_frame_end_i;
      if (al_valid_i) begin
        pixel_hcount_o <= al_hcount_i;
        pixel_vcount_o <= al_vcount_i;
      end
    end
  end

endmodule

// ==== rtl/ycrcb_convert.sv ====
`include "cam_config.svh"

module ycrcb_convert (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    px_valid_i,
  input  logic [`CAM_PIXEL_W-1:0] px_data_i,
  output logic                    yc_valid_o,
  output logic [`CAM_COLOR_W-1:0] yc_y_o,
  output logic [`CAM_COLOR_W-1:0] yc_cr_o,
  output logic [`CAM_COLOR_W-1:0] yc_cb_o
);

  // expand exactly like the rgb branch
  logic [`CAM_COLOR_W-1:0] r_exp;
  logic [`CAM_COLOR_W-1:0] g_exp;
  logic [`CAM_COLOR_W-1:0] b_exp;

  assign r_exp = {px_data_i[15:11], 3'b000};
  assign g_exp = {px_data_i[10:5], 2'b00};
  assign b_exp = {px_data_i[4:0], 3'b000};

  // ======================================================================
  // stage 1: coefficient products
  // ======================================================================
  // all magnitudes, the signs are applied in the sums
  logic [15:0] y_r, y_g, y_b;
  logic [15:0] cr_r, cr_g, cr_b;
  logic [15:0] cb_r, cb_g, cb_b;

  always_ff @(posedge clk_camera) begin
    y_r  <= r_exp * 16'd66;
    y_g  <= g_exp * 16'd129;
    y_b  <= b_exp * 16'd25;
    cr_r <= r_exp * 16'd112;
    cr_g <= g_exp * 16'd94;
    cr_b <= b_exp * 16'd18;
    cb_r <= r_exp * 16'd38;
    cb_g <= g_exp * 16'd74;
    cb_b <= b_exp * 16'd112;
  end

  // ======================================================================
  // stage 2: signed sums with rounding term
  // ======================================================================
  // modulo 2^16 arithmetic, bits 15:8 still hold the floor of sum/256
  logic [15:0] y_sum;
  logic [15:0] cr_sum;
  logic [15:0] cb_sum;

  always_ff @(posedge clk_camera) begin
    y_sum  <= y_r + y_g + y_b + 16'd128;
    cr_sum <= cr_r - cr_g - cr_b + 16'd128;
    cb_sum <= cb_b - cb_r - cb_g + 16'd128;
  end

  // ======================================================================
  // stage 3: shift and offset
  // ======================================================================
  // results stay inside 16..240 so no clamp is required
  always_ff @(posedge clk_camera) begin
    yc_y_o  <= y_sum[15:8] + 8'd16;
    yc_cr_o <= cr_sum[15:8] + 8'd128;
    yc_cb_o <= cb_sum[15:8] + 8'd128;
  end

  // strobe follows the three data stages
  logic [2:0] valid_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], px_valid_i};
    end
  end

  assign yc_valid_o = valid_q[2];

endmodule

// ==== rtl/rgb_align_pipe.sv ====
`include "cam_config.svh"

module rgb_align_pipe (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     px_valid_i,
  input  logic [`CAM_PIXEL_W-1:0]  px_data_i,
  input  logic [`CAM_HCOUNT_W-1:0] px_hcount_i,
  input  logic [`CAM_VCOUNT_W-1:0] px_vcount_i,
  input  logic                     frame_end_i,
  output logic                     al_valid_o,
  output logic [`CAM_COLOR_W-1:0]  al_r_o,
  output logic [`CAM_COLOR_W-1:0]  al_g_o,
  output logic [`CAM_COLOR_W-1:0]  al_b_o,
  output logic [`CAM_HCOUNT_W-1:0] al_hcount_o,
  output logic [`CAM_VCOUNT_W-1:0] al_vcount_o,
  output logic                     al_frame_end_o
);

  // same depth as the ycrcb converter so both branches meet
  localparam int DEPTH = `CAM_CONV_LATENCY;

  // rgb565 to 8 bits per color with zero-filled low bits
  logic [3*`CAM_COLOR_W-1:0] rgb_exp;
  assign rgb_exp = {px_data_i[15:11], 3'b000, px_data_i[10:5], 2'b00, px_data_i[4:0], 3'b000};

  logic [DEPTH-1:0]          valid_q;
  logic [DEPTH-1:0]          frame_end_q;
  logic [3*`CAM_COLOR_W-1:0] rgb_q    [DEPTH];
  logic [`CAM_HCOUNT_W-1:0]  hcount_q [DEPTH];
  logic [`CAM_VCOUNT_W-1:0]  vcount_q [DEPTH];

  // pixel color shift
  always_ff @(posedge clk_camera) begin
    rgb_q[0] <= rgb_exp;
    for (int i = 1; i < DEPTH; i++) begin
      rgb_q[i] <= rgb_q[i-1];
    end
  end

  // strobe, flag and position shift along together
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q     <= '0;
      frame_end_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        hcount_q[i] <= '0;
        vcount_q[i] <= '0;
      end
    end else begin
      valid_q[0]     <= px_valid_i;
      frame_end_q[0] <= px_valid_i & frame_end_i;
      hcount_q[0]    <= px_hcount_i;
      vcount_q[0]    <= px_vcount_i;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i]     <= valid_q[i-1];
        frame_end_q[i] <= frame_end_q[i-1];
        hcount_q[i]    <= hcount_q[i-1];
        vcount_q[i]    <= vcount_q[i-1];
      end
    end
  end

  assign al_valid_o                = valid_q[DEPTH-1];
  assign al_frame_end_o            = frame_end_q[DEPTH-1];
  assign {al_r_o, al_g_o, al_b_o}  = rgb_q[DEPTH-1];
  assign al_hcount_o               = hcount_q[DEPTH-1];
  assign al_vcount_o               = vcount_q[DEPTH-1];

endmodule

// ==== rtl/pixel_reconstruct.sv ====
`include "cam_config.svh"

module pixel_reconstruct
  import cam_pkg::*;
#(
  parameter int H_PIXELS = `CAM_H_PIXELS,
  parameter int V_LINES  = `CAM_V_LINES
) (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic [7:0]               camera_d_i,
  input  logic                     cam_pclk_i,
  input  logic                     cam_hsync_i,
  input  logic                     cam_vsync_i,
  output logic                     px_valid_o,
  output logic [`CAM_PIXEL_W-1:0]  px_data_o,
  output logic [`CAM_HCOUNT_W-1:0] px_hcount_o,
  output logic [`CAM_VCOUNT_W-1:0] px_vcount_o,
  output logic                     frame_end_o
);

  // last position of the frame, for the end-of-frame flag
  localparam logic [`CAM_HCOUNT_W-1:0] LAST_COL = `CAM_HCOUNT_W'(H_PIXELS - 1);
  localparam logic [`CAM_VCOUNT_W-1:0] LAST_ROW = `CAM_VCOUNT_W'(V_LINES - 1);

  // ======================================================================
  // input synchronizers
  // ======================================================================
  logic [7:0] d_meta;
  logic [7:0] d_sync;
  logic       pclk_meta;
  logic       pclk_sync;
  logic       pclk_prev;
  logic       hsync_meta;
  logic       hsync_sync;
  logic       hsync_prev;
  logic       vsync_meta;
  logic       vsync_sync;

  // camera data bus, two flops so it lines up with the pclk path
  always_ff @(posedge clk_camera) begin
    d_meta <= camera_d_i;
    d_sync <= d_meta;
  end

  // control lines plus one extra flop each for edge detection
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_meta  <= 1'b0;
      pclk_sync  <= 1'b0;
      pclk_prev  <= 1'b0;
      hsync_meta <= 1'b0;
      hsync_sync <= 1'b0;
      hsync_prev <= 1'b0;
      vsync_meta <= 1'b0;
      vsync_sync <= 1'b0;
    end else begin
      pclk_meta  <= cam_pclk_i;
      pclk_sync  <= pclk_meta;
      pclk_prev  <= pclk_sync;
      hsync_meta <= cam_hsync_i;
      hsync_sync <= hsync_meta;
      hsync_prev <= hsync_sync;
      vsync_meta <= cam_vsync_i;
      vsync_sync <= vsync_meta;
    end
  end

  logic byte_capture;
  logic hsync_fall;

  // a byte is taken on a pclk rise while the line is active
  assign byte_capture = pclk_sync & ~pclk_prev & hsync_sync;
  // end of line
  assign hsync_fall   = hsync_prev & ~hsync_sync;

  // ======================================================================
  // byte pairing and position counters
  // ======================================================================
  byte_phase_e                phase;
  logic [7:0]                 high_byte;
  logic [`CAM_HCOUNT_W-1:0]   hcount;
  logic [`CAM_VCOUNT_W-1:0]   vcount;

  // high byte is parked until its low byte shows up
  always_ff @(posedge clk_camera) begin
    if (byte_capture) begin
      if (phase == PH_HIGH) begin
        high_byte <= d_sync;
      end else begin
        px_data_o <= {high_byte, d_sync};
      end
    end
  end

  // hcount/vcount hold the position of the next pixel to finish
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase       <= PH_HIGH;
      hcount      <= '0;
      vcount      <= '0;
      px_valid_o  <= 1'b0;
      px_hcount_o <= '0;
      px_vcount_o <= '0;
      frame_end_o <= 1'b0;
    end else begin
      // strobes last one cycle
      px_valid_o  <= 1'b0;
      frame_end_o <= 1'b0;
      if (vsync_sync) begin
        // new frame, restart at the top left corner
        phase  <= PH_HIGH;
        hcount <= '0;
        vcount <= '0;
      end else if (hsync_fall) begin
        phase  <= PH_HIGH;
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (byte_capture) begin
        case (phase)
          PH_HIGH: begin
            phase <= PH_LOW;
          end
          PH_LOW: begin
            phase       <= PH_HIGH;
            px_valid_o  <= 1'b1;
            px_hcount_o <= hcount;
            px_vcount_o <= vcount;
            frame_end_o <= (hcount == LAST_COL) && (vcount == LAST_ROW);
            hcount      <= hcount + 1'b1;
          end
          default: begin
            phase <= PH_HIGH;
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/cam_pkg.sv ====
package cam_pkg;

  // ======================================================================
  // channel select codes
  // ======================================================================
  // bit 2 picks the luma/chroma group, low bits pick the channel
  // codes 3'b011 and 3'b111 are not valid and select zero
  typedef enum logic [2:0] {
    CH_GREEN = 3'b000,
    CH_RED   = 3'b001,
    CH_BLUE  = 3'b010,
    CH_Y     = 3'b100,
    CH_CR    = 3'b101,
    CH_CB    = 3'b110
  } channel_e;

  // ======================================================================
  // display modes
  // ======================================================================
  typedef enum logic [1:0] {
    // camera image as received
    MODE_CAMERA  = 2'b00,
    // selected channel as a gray level
    MODE_CHANNEL = 2'b01,
    // key mask as white or black
    MODE_MASK    = 2'b10,
    // luma gray with masked pixels in the overlay color
    MODE_OVERLAY = 2'b11
  } display_mode_e;

  // which byte of the pixel the camera sends next
  typedef enum logic {
    PH_HIGH = 1'b0,
    PH_LOW  = 1'b1
  } byte_phase_e;

endpackage

// ==== rtl/cam_config.svh ====
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// ======================================================================
// frame geometry
// ======================================================================
// default active frame, one camera line per hsync high period
`define CAM_H_PIXELS 1280
`define CAM_V_LINES 720

// position counter widths, sized for the default frame
`define CAM_HCOUNT_W 11
`define CAM_VCOUNT_W 10

// ======================================================================
// pixel formats
// ======================================================================
// raw rgb565 pixel as rebuilt from two camera bytes
`define CAM_PIXEL_W 16
// one expanded color or luma/chroma channel
`define CAM_COLOR_W 8

// converter depth in cycles, the rgb branch delays by the same amount
`define CAM_CONV_LATENCY 3

// overlay color for masked pixels (magenta)
`define CAM_MASK_COLOR 24'hFF00FF

`endif
